/* all.f */
+incdir+tb
source/eth_rx_pkg.sv
source/frame_buf_if.sv
source/mii_rx_framer.sv
source/host_rd_port.sv
source/buf_arbiter.sv
source/frame_buf_ram.sv
source/eth_rx_top.sv
tb/eth_rx_tb.sv

/* run_sim.sh */
#!/bin/sh

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
   --top-module eth_rx_tb -Mdir obj_dir -f all.f
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

out=$(./obj_dir/Veth_rx_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
   echo "Simulation binary returned status $status"
   exit 1
fi

if printf '%s\n' "$out" | grep -qx "Simulation passed"; then
   exit 0
fi
exit 1

/* tb/eth_rx_tb_frames.svh */
`ifndef ETH_RX_TB_FRAMES_SVH
`define ETH_RX_TB_FRAMES_SVH

// Reflected CRC-32 over tx_bytes and complemented as sent on the wire
function automatic logic [31:0] frame_fcs();
   logic [31:0] r;
   r = '1;
   foreach (tx_bytes[i]) begin
      for (int b = 0; b < 8; b++) begin
         if (r[0] ^ tx_bytes[i][b]) begin
            r = (r >> 1) ^ 32'hEDB8_8320;
         end else begin
            r = r >> 1;
         end
      end
   end
   return ~r;
endfunction

// Destination, source, EtherType, random payload, then FCS low byte first
task automatic build_frame(input logic [47:0] dst, input int len, input bit bad_fcs);
   logic [31:0] rnd;
   logic [31:0] fcs;
   tx_bytes.delete();
   for (int i = 5; i >= 0; i--) begin
      tx_bytes.push_back(dst[i*8 +: 8]);
   end
   for (int i = 5; i >= 0; i--) begin
      tx_bytes.push_back(SRC_MAC[i*8 +: 8]);
   end
   tx_bytes.push_back(8'h08);
   tx_bytes.push_back(8'h00);
   for (int i = 0; i < len; i++) begin
      rnd = $urandom();
      tx_bytes.push_back(rnd[7:0]);
   end
   fcs = frame_fcs();
   if (bad_fcs) begin
      fcs = fcs ^ 32'h0000_0100;
   end
   for (int i = 0; i < 4; i++) begin
      tx_bytes.push_back(fcs[i*8 +: 8]);
   end
endtask

task automatic drive_nibble(input logic [3:0] n);
   rx_dv   = 1'b1;
   rx_data = n;
   tick();
endtask

// Preamble and SFD then each byte low nibble first
task automatic send_frame(input logic [47:0] dst, input int len, input bit bad_fcs);
   build_frame(dst, len, bad_fcs);
   repeat (15) drive_nibble(4'h5);
   drive_nibble(SFD_NIBBLE);
   foreach (tx_bytes[i]) begin
      drive_nibble(tx_bytes[i][3:0]);
      drive_nibble(tx_bytes[i][7:4]);
   end
   rx_dv   = 1'b0;
   rx_data = '0;
endtask

`endif

/* tb/eth_rx_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module eth_rx_tb;
   import eth_rx_pkg::*;

   localparam int          BUF_ADDR_W = 11;
   localparam logic [47:0] MY_MAC     = 48'h0200_0000_0001;
   localparam logic [47:0] OTHER_MAC  = 48'h0400_0000_0001;
   localparam logic [47:0] SRC_MAC    = 48'h0200_0000_00AA;

   logic                  RX_CLK = 1'b0;
   logic                  ETH_PHY_RESETN;
   logic [3:0]            rx_data;
   logic                  rx_dv;
   logic                  rcv_ack;
   logic                  rd_req;
   logic [BUF_ADDR_W-1:0] rd_addr;
   logic [7:0]            rd_data;
   logic                  rd_valid;
   logic                  data_rcvd;
   logic [BUF_ADDR_W-1:0] rcv_size;
   logic                  crc_ok;
   logic                  phy_dv_detected;

   logic [7:0] tx_bytes [$];
   // Expected buffer contents
   logic [7:0] shadow [2**BUF_ADDR_W];
   int pay_len [7];
   int errors = 0;
   int tests_run = 0;
   int tests_failed = 0;
   int valid_pulse_errors = 0;
   int flag_hold_errors = 0;
   int req_count = 0;
   int valid_count = 0;
   int cycles = 0;
   int cycle_limit = 0;
   int max_lat = 0;

   eth_rx_top #(.MAC_ADDR(MY_MAC), .BUF_ADDR_W(BUF_ADDR_W)) dut (.*);

   always #4 RX_CLK = ~RX_CLK;

   task automatic tick();
      @(posedge RX_CLK);
      #1;
   endtask

   `include "eth_rx_tb_frames.svh"

   task automatic check_value(input int got, input int exp, input string what);
      assert (got == exp) else begin
         $display("ERROR @ %0d ns: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
         errors++;
      end
   endtask

   task automatic read_byte(input logic [BUF_ADDR_W-1:0] a, output logic [7:0] d,
                            output int lat);
      rd_req  = 1'b1;
      rd_addr = a;
      tick();
      rd_req = 1'b0;
      lat    = 1;
      while (!rd_valid) begin
         tick();
         lat++;
      end
      d = rd_data;
   endtask

   // Framer idle here so every read takes two cycles
   task automatic verify_buffer(input int n);
      logic [7:0] d;
      int lat;
      for (int i = 0; i < n; i++) begin
         read_byte(i[BUF_ADDR_W-1:0], d, lat);
         check_value(int'(d), int'(shadow[i]), "buffer byte");
         check_value(lat, 2, "read latency");
      end
   endtask

   task automatic check_accepted(input bit exp_crc_ok);
      int n;
      n = 0;
      while (!data_rcvd && n < 4) begin
         tick();
         n++;
      end
      assert (n <= 3) else begin
         $display("ERROR @ %0d ns: data_rcvd not set within 3 cycles", $time);
         errors++;
      end
      check_value(int'(rcv_size), tx_bytes.size(), "rcv_size");
      check_value(int'(crc_ok), int'(exp_crc_ok), "crc_ok");
      foreach (tx_bytes[i]) begin
         shadow[i] = tx_bytes[i];
      end
   endtask

   task automatic ack_frame();
      rcv_ack = 1'b1;
      tick();
      rcv_ack = 1'b0;
      check_value(int'(data_rcvd), 0, "data_rcvd after rcv_ack");
   endtask

   task automatic report_test(input string name, input int errs_before);
      tests_run++;
      if (errors == errs_before) begin
         $display("Test %0d %s: ok", tests_run, name);
      end else begin
         $display("Test %0d %s: %0d errors", tests_run, name, errors - errs_before);
         tests_failed++;
      end
   endtask

   assert property (@(posedge RX_CLK) disable iff (!ETH_PHY_RESETN) rd_valid |=> !rd_valid)
   else begin
      valid_pulse_errors++;
      $display("ERROR @ %0d ns: rd_valid high for two cycles", $time);
   end

   // Flag only falls on an acknowledge
   assert property (@(posedge RX_CLK) disable iff (!ETH_PHY_RESETN)
                    data_rcvd && !rcv_ack |=> data_rcvd)
   else begin
      flag_hold_errors++;
      $display("ERROR @ %0d ns: data_rcvd fell without rcv_ack", $time);
   end

   always @(posedge RX_CLK) begin
      if (rd_req) begin
         req_count++;
      end
      if (rd_valid) begin
         valid_count++;
      end
   end

   always @(posedge RX_CLK) begin
      cycles++;
      if (cycles > cycle_limit) begin
         $display("Timeout: run did not finish within %0d cycles", cycle_limit);
         $display("Simulation failed");
         $finish;
      end
   end

   initial begin
      int nibbles;
      int errs;
      int lat;
      logic [7:0] d;
      logic [31:0] rnd;
      int size_before;

      ETH_PHY_RESETN = 1'b0;
      rx_data        = '0;
      rx_dv          = 1'b0;
      rcv_ack        = 1'b0;
      rd_req         = 1'b0;
      rd_addr        = '0;
      void'($urandom(32'ha08b_ca10));
      // First frame is long so its bytes cover the contention reads
      pay_len[0] = $urandom_range(90, 70);
      for (int i = 1; i < 6; i++) begin
         pay_len[i] = $urandom_range(60, 20);
      end
      pay_len[6] = $urandom_range(20, 10);
      nibbles = 0;
      foreach (pay_len[i]) begin
         nibbles += 16 + 2 * (18 + pay_len[i]);
      end
      cycle_limit = 4 * nibbles + 2000;
      tick();
      tick();
      ETH_PHY_RESETN = 1'b1;
      tick();

      errs = errors;
      check_value(int'(data_rcvd), 0, "data_rcvd");
      check_value(int'(rd_valid), 0, "rd_valid");
      check_value(int'(crc_ok), 0, "crc_ok");
      check_value(int'(phy_dv_detected), 0, "phy_dv_detected");
      check_value(int'(rcv_size), 0, "rcv_size");
      report_test("reset state", errs);

      errs = errors;
      send_frame(MY_MAC, pay_len[0], 1'b0);
      check_accepted(1'b1);
      check_value(int'(phy_dv_detected), 1, "phy_dv_detected");
      verify_buffer(tx_bytes.size());
      ack_frame();
      report_test("good unicast frame", errs);

      errs = errors;
      send_frame(MY_MAC, pay_len[1], 1'b1);
      check_accepted(1'b0);
      ack_frame();
      report_test("corrupted CRC", errs);

      errs = errors;
      send_frame(OTHER_MAC, pay_len[2], 1'b0);
      repeat (4) tick();
      check_value(int'(data_rcvd), 0, "data_rcvd after foreign frame");
      send_frame(BROADCAST_MAC, pay_len[3], 1'b0);
      check_accepted(1'b1);
      report_test("address filtering", errs);

      // Broadcast frame still held
      errs = errors;
      size_before = tx_bytes.size();
      send_frame(MY_MAC, pay_len[4], 1'b0);
      repeat (4) tick();
      check_value(int'(rcv_size), size_before, "rcv_size after dropped frame");
      verify_buffer(size_before);
      ack_frame();
      send_frame(MY_MAC, pay_len[5], 1'b0);
      check_accepted(1'b1);
      verify_buffer(tx_bytes.size());
      ack_frame();
      report_test("frame flag", errs);

      // Reads above the short frame hit bytes of earlier frames
      errs = errors;
      fork
         send_frame(MY_MAC, pay_len[6], 1'b0);
         begin
            repeat (20) tick();
            for (int a = 40; a < 70; a++) begin
               rnd = $urandom();
               if (rnd[0]) begin
                  tick();
               end
               read_byte(a[BUF_ADDR_W-1:0], d, lat);
               check_value(int'(d), int'(shadow[a]), "byte read under contention");
               if (lat > max_lat) begin
                  max_lat = lat;
               end
            end
         end
      join
      assert (max_lat > 2) else begin
         $display("No host read was ever delayed by a framer write");
         errors++;
      end
      check_accepted(1'b1);
      verify_buffer(tx_bytes.size());
      ack_frame();
      report_test("contention", errs);

      assert (req_count == valid_count) else begin
         $display("ERROR @ %0d ns: %0d read requests but %0d rd_valid pulses",
                  $time, req_count, valid_count);
         errors++;
      end
      $display("Summary: %0d tests, %0d failed, %0d check errors, %0d protocol errors",
               tests_run, tests_failed, errors, valid_pulse_errors + flag_hold_errors);
      if (errors == 0 && tests_failed == 0 && valid_pulse_errors + flag_hold_errors == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* source/eth_rx_top.sv */
`timescale 1ns/100ps
`default_nettype none

module eth_rx_top #(
   parameter logic [eth_rx_pkg::MAC_ADDR_W-1:0] MAC_ADDR = 48'h0200_0000_0001,
   parameter int BUF_ADDR_W = 11
) (
   input  wire                   RX_CLK,
   input  wire                   ETH_PHY_RESETN,
   input  wire  [3:0]            rx_data,
   input  wire                   rx_dv,
   input  wire                   rcv_ack,
   input  wire                   rd_req,
   input  wire  [BUF_ADDR_W-1:0] rd_addr,
   output logic [7:0]            rd_data,
   output logic                  rd_valid,
   output logic                  data_rcvd,
   output logic [BUF_ADDR_W-1:0] rcv_size,
   output logic                  crc_ok,
   output logic                  phy_dv_detected
);

   logic                  ram_en;
   logic                  ram_we;
   logic [BUF_ADDR_W-1:0] ram_addr;
   logic [7:0]            ram_wdata;
   logic [7:0]            ram_rdata;

   // Framer and host side buffer paths
   frame_buf_if #(.BUF_ADDR_W(BUF_ADDR_W)) fb_rx ();
   frame_buf_if #(.BUF_ADDR_W(BUF_ADDR_W)) fb_host ();

   mii_rx_framer #(.MAC_ADDR(MAC_ADDR), .BUF_ADDR_W(BUF_ADDR_W)) u_framer (
      .RX_CLK          (RX_CLK),
      .ETH_PHY_RESETN  (ETH_PHY_RESETN),
      .rx_data         (rx_data),
      .rx_dv           (rx_dv),
      .rcv_ack         (rcv_ack),
      .fb              (fb_rx.requester),
      .data_rcvd       (data_rcvd),
      .rcv_size        (rcv_size),
      .crc_ok          (crc_ok),
      .phy_dv_detected (phy_dv_detected)
   );

   host_rd_port #(.BUF_ADDR_W(BUF_ADDR_W)) u_host (
      .RX_CLK         (RX_CLK),
      .ETH_PHY_RESETN (ETH_PHY_RESETN),
      .rd_req         (rd_req),
      .rd_addr        (rd_addr),
      .rd_data        (rd_data),
      .rd_valid       (rd_valid),
      .fb             (fb_host.requester)
   );

   buf_arbiter #(.BUF_ADDR_W(BUF_ADDR_W)) u_arb (
      .RX_CLK         (RX_CLK),
      .ETH_PHY_RESETN (ETH_PHY_RESETN),
      .rx_port        (fb_rx.arbiter),
      .host_port      (fb_host.arbiter),
      .ram_en         (ram_en),
      .ram_we         (ram_we),
      .ram_addr       (ram_addr),
      .ram_wdata      (ram_wdata),
      .ram_rdata      (ram_rdata)
   );

   frame_buf_ram #(.BUF_ADDR_W(BUF_ADDR_W)) u_ram (
      .RX_CLK    (RX_CLK),
      .ram_en    (ram_en),
      .ram_we    (ram_we),
      .ram_addr  (ram_addr),
      .ram_wdata (ram_wdata),
      .ram_rdata (ram_rdata)
   );

endmodule

`default_nettype wire

/* source/frame_buf_ram.sv */
`timescale 1ns/100ps
`default_nettype none

module frame_buf_ram #(
   parameter int BUF_ADDR_W = 11
) (
   input  wire                   RX_CLK,
   input  wire                   ram_en,
   input  wire                   ram_we,
   input  wire  [BUF_ADDR_W-1:0] ram_addr,
   input  wire  [7:0]            ram_wdata,
   output logic [7:0]            ram_rdata
);

   localparam int DEPTH = 2 ** BUF_ADDR_W;

   logic [7:0] mem [DEPTH];

   // Write-first so the written byte also appears on the read port
   always_ff @(posedge RX_CLK) begin
      if (ram_en) begin
         if (ram_we) begin
            mem[ram_addr] <= ram_wdata;
            ram_rdata     <= ram_wdata;
         end else begin
            ram_rdata <= mem[ram_addr];
         end
      end
   end

endmodule

`default_nettype wire

/* source/buf_arbiter.sv */
`timescale 1ns/100ps
`default_nettype none

module buf_arbiter #(
   parameter int BUF_ADDR_W = 11
) (
   input  wire                   RX_CLK,
   input  wire                   ETH_PHY_RESETN,
   frame_buf_if.arbiter          rx_port,
   frame_buf_if.arbiter          host_port,
   output logic                  ram_en,
   output logic                  ram_we,
   output logic [BUF_ADDR_W-1:0] ram_addr,
   output logic [7:0]            ram_wdata,
   input  wire  [7:0]            ram_rdata
);
   import eth_rx_pkg::*;

   buf_owner_t owner;
   buf_owner_t rd_owner;

   // Framer cannot stall and always wins
   always_comb begin
      if (rx_port.req) begin
         owner = own_framer;
      end else if (host_port.req) begin
         owner = own_host;
      end else begin
         owner = own_none;
      end
   end

   assign rx_port.gnt   = (owner == own_framer);
   assign host_port.gnt = (owner == own_host);
   assign ram_en        = (owner != own_none);

   always_comb begin
      case (owner)
         own_framer: begin
            ram_we    = rx_port.we;
            ram_addr  = rx_port.addr;
            ram_wdata = rx_port.wdata;
         end
         own_host: begin
            ram_we    = host_port.we;
            ram_addr  = host_port.addr;
            ram_wdata = host_port.wdata;
         end
         default: begin
            ram_we    = 1'b0;
            ram_addr  = '0;
            ram_wdata = '0;
         end
      endcase
   end

   // Who gets the read data next cycle
   always_ff @(posedge RX_CLK or negedge ETH_PHY_RESETN) begin
      if (!ETH_PHY_RESETN) begin
         rd_owner <= own_none;
      end else if (ram_we) begin
         rd_owner <= own_none;
      end else begin
         rd_owner <= owner;
      end
   end

   assign rx_port.rdata   = (rd_owner == own_framer) ? ram_rdata : '0;
   assign host_port.rdata = (rd_owner == own_host) ? ram_rdata : '0;

endmodule

`default_nettype wire

/* source/host_rd_port.sv */
`timescale 1ns/100ps
`default_nettype none

module host_rd_port #(
   parameter int BUF_ADDR_W = 11
) (
   input  wire                   RX_CLK,
   input  wire                   ETH_PHY_RESETN,
   input  wire                   rd_req,
   input  wire  [BUF_ADDR_W-1:0] rd_addr,
   output logic [7:0]            rd_data,
   output logic                  rd_valid,
   frame_buf_if.requester        fb
);

   logic                  pending;
   logic [BUF_ADDR_W-1:0] addr_q;
   logic                  rd_issued;

   // A fresh request goes straight to the arbiter and a blocked one is held
   assign fb.req   = pending || rd_req;
   assign fb.addr  = pending ? addr_q : rd_addr;
   assign fb.we    = 1'b0;
   assign fb.wdata = '0;

   always_ff @(posedge RX_CLK or negedge ETH_PHY_RESETN) begin
      if (!ETH_PHY_RESETN) begin
         pending   <= 1'b0;
         rd_issued <= 1'b0;
         rd_valid  <= 1'b0;
      end else begin
         rd_issued <= fb.req && fb.gnt;
         rd_valid  <= rd_issued;
         if (pending) begin
            if (fb.gnt) begin
               pending <= 1'b0;
            end
         end else if (rd_req && !fb.gnt) begin
            // Framer owns the buffer this cycle
            pending <= 1'b1;
         end
      end
   end

   always_ff @(posedge RX_CLK) begin
      if (rd_req && !pending) begin
         addr_q <= rd_addr;
      end
      if (rd_issued) begin
         rd_data <= fb.rdata;
      end
   end

endmodule

`default_nettype wire

/* source/mii_rx_framer.sv */
`timescale 1ns/100ps
`default_nettype none

module mii_rx_framer #(
   parameter logic [eth_rx_pkg::MAC_ADDR_W-1:0] MAC_ADDR = 48'h0200_0000_0001,
   parameter int BUF_ADDR_W = 11
) (
   input  wire                   RX_CLK,
   input  wire                   ETH_PHY_RESETN,
   input  wire  [3:0]            rx_data,
   input  wire                   rx_dv,
   input  wire                   rcv_ack,
   frame_buf_if.requester        fb,
   output logic                  data_rcvd,
   output logic [BUF_ADDR_W-1:0] rcv_size,
   output logic                  crc_ok,
   output logic                  phy_dv_detected
);
   import eth_rx_pkg::*;

   rx_state_t             state;
   logic                  nib_hi;
   logic [3:0]            lo_nib;
   logic [7:0]            rx_byte;
   logic [7:0]            byte_q;
   logic                  wr_pend;
   logic [BUF_ADDR_W-1:0] wr_addr;
   logic [2:0]            hdr_cnt;
   logic                  uni_ok;
   logic                  bc_ok;
   logic                  uni_next;
   logic                  bc_next;
   logic [31:0]           crc;

   // Eight bits through the CRC register LSB first as on the wire
   function automatic logic [31:0] crc32_byte(input logic [31:0] crc_in,
                                              input logic [7:0]  d);
      logic [31:0] c;
      c = crc_in;
      for (int i = 0; i < 8; i++) begin
         if (c[31] ^ d[i]) begin
            c = {c[30:0], 1'b0} ^ CRC_POLY;
         end else begin
            c = {c[30:0], 1'b0};
         end
      end
      return c;
   endfunction

   // Low nibble arrives first
   assign rx_byte = {rx_data, lo_nib};

   // Destination address byte k is compared MSB first
   assign uni_next = uni_ok && (rx_byte == MAC_ADDR[(5 - hdr_cnt) * 8 +: 8]);
   assign bc_next  = bc_ok && (rx_byte == BROADCAST_MAC[(5 - hdr_cnt) * 8 +: 8]);

   always_ff @(posedge RX_CLK) begin
      if (rx_dv && !nib_hi) begin
         lo_nib <= rx_data;
      end
      if (rx_dv && nib_hi) begin
         byte_q <= rx_byte;
      end
   end

   always_ff @(posedge RX_CLK or negedge ETH_PHY_RESETN) begin
      if (!ETH_PHY_RESETN) begin
         state   <= rx_idle;
         nib_hi  <= 1'b0;
         wr_pend <= 1'b0;
         wr_addr <= '0;
         hdr_cnt <= '0;
         uni_ok  <= 1'b0;
         bc_ok   <= 1'b0;
         crc     <= '1;
      end else begin
         wr_pend <= 1'b0;
         if (wr_pend) begin
            wr_addr <= wr_addr + 1'b1;
         end
         if (rx_dv) begin
            nib_hi <= !nib_hi;
         end
         case (state)
            rx_idle: begin
               if (rx_dv) begin
                  state <= rx_preamble;
               end
            end
            rx_preamble: begin
               if (!rx_dv) begin
                  state <= rx_idle;
               end else if (rx_data == SFD_NIBBLE) begin
                  nib_hi  <= 1'b0;
                  wr_addr <= '0;
                  hdr_cnt <= '0;
                  uni_ok  <= 1'b1;
                  bc_ok   <= 1'b1;
                  crc     <= '1;
                  // Previous frame not yet taken by the host
                  state   <= data_rcvd ? rx_drop : rx_header;
               end
            end
            rx_header: begin
               if (!rx_dv) begin
                  state <= rx_idle;
               end else if (nib_hi) begin
                  if (!uni_next && !bc_next) begin
                     state <= rx_drop;
                  end else begin
                     wr_pend <= 1'b1;
                     crc     <= crc32_byte(crc, rx_byte);
                     uni_ok  <= uni_next;
                     bc_ok   <= bc_next;
                     hdr_cnt <= hdr_cnt + 1'b1;
                     if (hdr_cnt == 3'd5) begin
                        state <= rx_payload;
                     end
                  end
               end
            end
            rx_payload: begin
               if (!rx_dv) begin
                  state <= rx_done;
               end else if (nib_hi) begin
                  wr_pend <= 1'b1;
                  crc     <= crc32_byte(crc, rx_byte);
               end
            end
            rx_drop: begin
               if (!rx_dv) begin
                  state <= rx_idle;
               end
            end
            default: begin
               state <= rx_idle;
            end
         endcase
      end
   end

   // Frame status toward the host
   always_ff @(posedge RX_CLK or negedge ETH_PHY_RESETN) begin
      if (!ETH_PHY_RESETN) begin
         data_rcvd       <= 1'b0;
         rcv_size        <= '0;
         crc_ok          <= 1'b0;
         phy_dv_detected <= 1'b0;
      end else begin
         if (rx_dv) begin
            phy_dv_detected <= 1'b1;
         end
         if (state == rx_done) begin
            data_rcvd <= 1'b1;
            rcv_size  <= wr_addr;
            crc_ok    <= (crc == CRC_RESIDUE);
         end else if (rcv_ack) begin
            data_rcvd <= 1'b0;
         end
      end
   end

   // Write-only requester with one byte the cycle after its high nibble
   assign fb.req   = wr_pend;
   assign fb.we    = wr_pend;
   assign fb.addr  = wr_addr;
   assign fb.wdata = byte_q;

endmodule

`default_nettype wire

/* source/frame_buf_if.sv */
`timescale 1ns/100ps
`default_nettype none

// One requester's path into the shared frame buffer
interface frame_buf_if #(
   parameter int BUF_ADDR_W = 11
) ();

   logic                  req;
   logic                  we;
   logic [BUF_ADDR_W-1:0] addr;
   logic [7:0]            wdata;
   logic                  gnt;
   // Valid the cycle after a granted read
   logic [7:0]            rdata;

   modport requester (
      output req, we, addr, wdata,
      input  gnt, rdata
   );

   modport arbiter (
      input  req, we, addr, wdata,
      output gnt, rdata
   );

endinterface

`default_nettype wire

/* source/eth_rx_pkg.sv */
`default_nettype none

package eth_rx_pkg;

   // Receive FSM states
   typedef enum logic [2:0] {
      rx_idle,
      rx_preamble,
      rx_header,
      rx_payload,
      rx_drop,
      rx_done
   } rx_state_t;

   // Current owner of the frame buffer port
   typedef enum logic [1:0] {
      own_none,
      own_framer,
      own_host
   } buf_owner_t;

   // Ethernet address width
   parameter int MAC_ADDR_W = 48;

   // Destination address of a broadcast frame
   parameter logic [MAC_ADDR_W-1:0] BROADCAST_MAC = 48'hFFFF_FFFF_FFFF;

   // High nibble of the 0xD5 start-of-frame delimiter
   parameter logic [3:0] SFD_NIBBLE = 4'hD;

   // CRC-32 generator polynomial in normal form
   parameter logic [31:0] CRC_POLY = 32'h04C1_1DB7;

   // Register value left after a good frame with its FCS
   parameter logic [31:0] CRC_RESIDUE = 32'hC704_DD7B;

endpackage

`default_nettype wire
